// File: verilog/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

	typedef struct packed {
		logic [3:0] addr;
	} axil_aw_t;

	// Strobe travels with the data but the mailbox always takes the full word
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [3:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Byte offsets of the register map
	typedef enum logic [3:0] {
		REG_DATA   = 4'h0,
		REG_STATUS = 4'h4,
		REG_THRESH = 4'h8,
		REG_CLEAR  = 4'hC
	} reg_addr_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_MEM,
		RD_RESP
	} rd_state_e;

	typedef struct packed {
		logic        empty;
		logic        full;
		logic [15:0] level;
	} fifo_status_t;

endpackage

`default_nettype wire

// File: verilog/two_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module two_port_ram #(
	parameter int ADDR_W = 4
) (
	input  logic              clk,
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [31:0]       wr_data,
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [31:0]       rd_data
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [31:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read, data one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  logic [31:0]            push_data,
	input  logic                   pop,
	output logic [31:0]            pop_data,
	output fifo_pkg::fifo_status_t status
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0]   count;
	logic              full;
	logic              empty;
	logic              push_ok;
	logic              pop_ok;

	// Flags come from occupancy, not from pointer compare
	assign full  = (count == (ADDR_W+1)'(DEPTH));
	assign empty = (count == '0);

	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Push and pop together leave the count alone
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign status.empty = empty;
	assign status.full  = full;
	assign status.level = 16'(count);

	two_port_ram #(
		.ADDR_W(ADDR_W)
	) ram (
		.clk    (clk),
		.wr_en  (push_ok),
		.wr_addr(wr_ptr),
		.wr_data(push_data),
		.rd_en  (pop_ok),
		.rd_addr(rd_ptr),
		.rd_data(pop_data)
	);

endmodule

`default_nettype wire

// File: verilog/fifo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_regs #(
	parameter int ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  fifo_pkg::axil_aw_t     aw,
	input  logic                   awvalid,
	output logic                   awready,
	input  fifo_pkg::axil_w_t      w,
	input  logic                   wvalid,
	output logic                   wready,
	output fifo_pkg::axil_b_t      b,
	output logic                   bvalid,
	input  logic                   bready,
	input  fifo_pkg::axil_ar_t     ar,
	input  logic                   arvalid,
	output logic                   arready,
	output fifo_pkg::axil_r_t      r,
	output logic                   rvalid,
	input  logic                   rready,
	output logic                   push,
	output logic [31:0]            push_data,
	output logic                   pop,
	input  logic [31:0]            pop_data,
	input  fifo_pkg::fifo_status_t status,
	output logic                   irq
);

	import fifo_pkg::*;

	rd_state_e       rd_state;
	logic [3:0]      rd_addr;
	logic            rd_empty;
	logic [31:0]     rd_word;
	logic [1:0]      rd_resp;
	logic [1:0]      wr_resp;
	logic            wr_go;
	logic            wr_hs;
	logic            ar_hs;
	logic [ADDR_W:0] thresh;
	logic            ovf;
	logic            unf;
	logic [31:0]     status_word;

	// Both ready lines go up together once, only with no response pending
	assign wr_go = awvalid && wvalid && !bvalid && !awready;
	assign wr_hs = awvalid && awready && wvalid && wready;
	assign ar_hs = arvalid && arready;

	assign arready = (rd_state == RD_IDLE);
	assign rvalid  = (rd_state == RD_RESP);

	assign push      = wr_hs && (aw.addr == REG_DATA);
	assign push_data = w.data;
	assign pop       = ar_hs && (ar.addr == REG_DATA);

	assign status_word = {status.level, 12'b0, unf, ovf, status.full, status.empty};

	always_comb begin
		case (aw.addr)
			REG_DATA, REG_THRESH, REG_CLEAR: wr_resp = RESP_OKAY;
			default:                         wr_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			thresh  <= '0;
		end else begin
			awready <= wr_go;
			wready  <= wr_go;
			if (wr_hs) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			// Threshold only needs the occupancy range
			if (wr_hs && aw.addr == REG_THRESH) begin
				thresh <= w.data[ADDR_W:0];
			end
		end
	end

	// Sticky flags, a new event wins over a clear in the same cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ovf <= 1'b0;
			unf <= 1'b0;
		end else begin
			if (wr_hs && aw.addr == REG_CLEAR && w.data[2]) begin
				ovf <= 1'b0;
			end
			if (wr_hs && aw.addr == REG_CLEAR && w.data[3]) begin
				unf <= 1'b0;
			end
			if (push && status.full) begin
				ovf <= 1'b1;
			end
			if (pop && status.empty) begin
				unf <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (ar_hs) begin
						rd_state <= RD_MEM;
					end
				end
				RD_MEM:  rd_state <= RD_RESP;
				RD_RESP: begin
					if (rready) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// RAM output is valid during RD_MEM
	always_comb begin
		rd_word = '0;
		rd_resp = RESP_OKAY;
		case (rd_addr)
			REG_DATA: begin
				if (!rd_empty) begin
					rd_word = pop_data;
				end
			end
			REG_STATUS: rd_word = status_word;
			REG_THRESH: rd_word = 32'(thresh);
			REG_CLEAR:  rd_word = '0;
			default:    rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			b.resp <= wr_resp;
		end
		if (ar_hs) begin
			rd_addr  <= ar.addr;
			rd_empty <= status.empty;
		end
		if (rd_state == RD_MEM) begin
			r.data <= rd_word;
			r.resp <= rd_resp;
		end
	end

	// Level interrupt, disabled while the threshold is zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			irq <= 1'b0;
		end else begin
			irq <= (thresh != '0) && (status.level[ADDR_W:0] >= thresh);
		end
	end

endmodule

`default_nettype wire

// File: verilog/fifo_mailbox.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_mailbox #(
	parameter int ADDR_W = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  fifo_pkg::axil_aw_t aw,
	input  logic               awvalid,
	output logic               awready,
	input  fifo_pkg::axil_w_t  w,
	input  logic               wvalid,
	output logic               wready,
	output fifo_pkg::axil_b_t  b,
	output logic               bvalid,
	input  logic               bready,
	input  fifo_pkg::axil_ar_t ar,
	input  logic               arvalid,
	output logic               arready,
	output fifo_pkg::axil_r_t  r,
	output logic               rvalid,
	input  logic               rready,
	output logic               irq
);

	import fifo_pkg::*;

	logic         push;
	logic [31:0]  push_data;
	logic         pop;
	logic [31:0]  pop_data;
	fifo_status_t status;

	// Bus side and FIFO control
	fifo_regs #(
		.ADDR_W(ADDR_W)
	) regs (
		.clk      (clk),
		.rst      (rst),
		.aw       (aw),
		.awvalid  (awvalid),
		.awready  (awready),
		.w        (w),
		.wvalid   (wvalid),
		.wready   (wready),
		.b        (b),
		.bvalid   (bvalid),
		.bready   (bready),
		.ar       (ar),
		.arvalid  (arvalid),
		.arready  (arready),
		.r        (r),
		.rvalid   (rvalid),
		.rready   (rready),
		.push     (push),
		.push_data(push_data),
		.pop      (pop),
		.pop_data (pop_data),
		.status   (status),
		.irq      (irq)
	);

	sync_fifo #(
		.ADDR_W(ADDR_W)
	) fifo (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.push_data(push_data),
		.pop      (pop),
		.pop_data (pop_data),
		.status   (status)
	);

endmodule

`default_nettype wire

// File: tests/fifo_mailbox_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_mailbox_sva (
	input logic                   clk,
	input logic                   rst,
	input fifo_pkg::axil_aw_t     aw,
	input logic                   awvalid,
	input logic                   awready,
	input fifo_pkg::axil_w_t      w,
	input logic                   wvalid,
	input logic                   wready,
	input fifo_pkg::axil_b_t      b,
	input logic                   bvalid,
	input logic                   bready,
	input fifo_pkg::axil_ar_t     ar,
	input logic                   arvalid,
	input logic                   arready,
	input fifo_pkg::axil_r_t      r,
	input logic                   rvalid,
	input logic                   rready,
	input logic                   push,
	input logic                   pop,
	input fifo_pkg::fifo_status_t status,
	input logic                   irq
);

	// Valid and payload held until the handshake
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("aw valid or payload changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(w))
		else $error("w valid or payload changed before wready");

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("ar valid or payload changed before arready");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(b))
		else $error("b valid or response changed before bready");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(r))
		else $error("r valid or data changed before rready");

	// Read latency through RD_MEM is fixed
	r_latency: assert property (@(posedge clk) disable iff (rst)
		$past(arvalid && arready, 2) |-> rvalid && !$past(rvalid))
		else $error("rvalid did not rise two cycles after the ar handshake");

	// FIFO flags follow accepted pushes and pops
	push_not_empty: assert property (@(posedge clk) disable iff (rst)
		push && !status.full |=> !status.empty)
		else $error("FIFO still empty after an accepted push");

	pop_not_full: assert property (@(posedge clk) disable iff (rst)
		pop && !status.empty |=> !status.full)
		else $error("FIFO still full after an accepted pop");

	irq_reset: assert property (@(posedge clk) $fell(rst) |-> !irq)
		else $error("irq high after reset");

endmodule

bind fifo_regs fifo_mailbox_sva sva (.*);

`default_nettype wire

// File: tests/tb_fifo_mailbox.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_mailbox;

	import fifo_pkg::*;

	localparam int ADDR_W     = 4;
	localparam int DEPTH      = 1 << ADDR_W;
	localparam int NUM_RANDOM = 150;
	// Every step is one access plus one status read
	localparam int NUM_OPS    = 2 * (NUM_RANDOM + 40);
	localparam int MAX_WAIT   = 20;

	logic        clk;
	logic        rst;
	axil_aw_t    aw;
	logic        awvalid;
	logic        awready;
	axil_w_t     w;
	logic        wvalid;
	logic        wready;
	axil_b_t     b;
	logic        bvalid;
	logic        bready;
	axil_ar_t    ar;
	logic        arvalid;
	logic        arready;
	axil_r_t     r;
	logic        rvalid;
	logic        rready;
	logic        irq;

	// Model of the mailbox
	logic [31:0] model_q[$];
	logic        model_ovf;
	logic        model_unf;
	logic [31:0] model_thresh;
	int          errors;

	fifo_mailbox #(.ADDR_W(ADDR_W)) uut (.*);

	always #20 clk = ~clk;

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge clk);
		#1;
		aw.addr = addr;
		w.data  = data;
		w.strb  = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!(awready && wready) && n < MAX_WAIT) begin
			n++;
			@(negedge clk);
		end
		if (n == MAX_WAIT)
			report_error("write address and data were never accepted");
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge clk);
		if (!bvalid)
			report_error("bvalid did not rise in the cycle after the write handshake");
		repeat ($urandom % 4) @(posedge clk);
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(negedge clk);
		resp = b.resp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge clk);
		#1;
		ar.addr = addr;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready && n < MAX_WAIT) begin
			n++;
			@(negedge clk);
		end
		if (n == MAX_WAIT)
			report_error("read address was never accepted");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		if (rvalid)
			report_error("rvalid rose one cycle after the read handshake");
		@(negedge clk);
		if (!rvalid)
			report_error("rvalid was not high two cycles after the read handshake");
		repeat ($urandom % 4) @(posedge clk);
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(negedge clk);
		data = r.data;
		resp = r.resp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// One access followed by irq and status checks against the model
	task automatic run_step(input int kind);
		logic [31:0] data;
		logic [31:0] exp;
		logic [1:0]  resp;
		logic [3:0]  addr;
		case (kind)
			0: begin
				data = $urandom;
				write_reg(REG_DATA, data, resp);
				if (model_q.size() < DEPTH)
					model_q.push_back(data);
				else
					model_ovf = 1'b1;
				check_word("b.resp", RESP_OKAY, resp);
			end
			1: begin
				read_reg(REG_DATA, data, resp);
				exp = 32'h0;
				if (model_q.size() == 0)
					model_unf = 1'b1;
				else
					exp = model_q.pop_front();
				check_word("r.data", exp, data);
				check_word("r.resp", RESP_OKAY, resp);
			end
			2: begin
				data = $urandom % (DEPTH + 1);
				write_reg(REG_THRESH, data, resp);
				model_thresh = data;
				check_word("b.resp", RESP_OKAY, resp);
			end
			3: begin
				read_reg(REG_THRESH, data, resp);
				check_word("r.data", model_thresh, data);
				check_word("r.resp", RESP_OKAY, resp);
			end
			4: begin
				write_reg(REG_CLEAR, 32'hFFFF_FFFF, resp);
				model_ovf = 1'b0;
				model_unf = 1'b0;
				check_word("b.resp", RESP_OKAY, resp);
			end
			5: begin
				write_reg(REG_STATUS, $urandom, resp);
				check_word("b.resp", RESP_SLVERR, resp);
			end
			default: begin
				// Low address bits set so it is never a register offset
				addr = 4'(($urandom % 4) * 4 + 1 + $urandom % 3);
				if ($urandom % 2) begin
					write_reg(addr, $urandom, resp);
					check_word("b.resp", RESP_SLVERR, resp);
				end else begin
					read_reg(addr, data, resp);
					check_word("r.data", 32'h0, data);
					check_word("r.resp", RESP_SLVERR, resp);
				end
			end
		endcase
		repeat (2) @(negedge clk);
		exp = 32'((model_thresh != 0) && (model_q.size() >= model_thresh));
		check_word("irq", exp, 32'(irq));
		read_reg(REG_STATUS, data, resp);
		exp = {16'(model_q.size()), 12'h0, model_unf, model_ovf,
			model_q.size() == DEPTH, model_q.size() == 0};
		check_word("status", exp, data);
		check_word("r.resp", RESP_OKAY, resp);
	endtask

	function automatic int pick_kind();
		int k;
		k = $urandom % 10;
		// Writes slightly ahead of reads so the FIFO reaches full
		if (k < 3)
			return 0;
		else if (k < 5)
			return 1;
		else
			return k - 3;
	endfunction

	initial begin
		void'($urandom(32'h09ee04fb));
		errors = 0;
		model_ovf = 1'b0;
		model_unf = 1'b0;
		model_thresh = 32'h0;
		clk = 1'b0;
		rst = 1'b1;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (!arready || awready || wready || bvalid || rvalid || irq)
			report_error("handshake outputs or irq not at their reset values");
		// Fill to full and one more for overflow
		repeat (DEPTH + 1)
			run_step(0);
		run_step(2);
		run_step(3);
		run_step(4);
		// Drain past empty for underflow
		repeat (DEPTH + 1)
			run_step(1);
		run_step(4);
		run_step(5);
		run_step(6);
		repeat (NUM_RANDOM)
			run_step(pick_kind());
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(NUM_OPS * 20 * 40);
		$display("Watchdog expired at %0t before all accesses completed", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/fifo_pkg.sv
verilog/two_port_ram.sv
verilog/sync_fifo.sv
verilog/fifo_regs.sv
verilog/fifo_mailbox.sv
tests/fifo_mailbox_sva.sv
tests/tb_fifo_mailbox.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_fifo_mailbox
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
